// ==== bench/decodeTopTb.sv ====
`include "decodeConsts.svh"

module decodeTopTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clkPeriod = 20;
    localparam int resetCycles = 16;
    localparam int totalVectors = 200;
    localparam time timeLimit = 2 * totalVectors * clkPeriod + resetCycles * clkPeriod;

    localparam decodePkg::ctrlT idleCtrl = '{decodePkg::ALU_ADD, 1'b0, decodePkg::SELB_RS2,
        1'b0, decodePkg::MEM_DISABLE, decodePkg::SIZE_BYTE, 1'b0, 1'b0, 1'b0};

    logic clk;
    logic arstN;
    logic hold;
    decodePkg::wordT instruction;
    decodePkg::wordT pcIn;
    decodePkg::regSelT regSel;
    decodePkg::wordT imm;
    decodePkg::ctrlT ctrl;
    logic regWriteCollision;
    decodePkg::wordT pc;

    integer seed = 56642;
    int passCount = 0;
    int failCount = 0;
    int failMark = 0;
    logic compareOn = 1'b0;

    // Expected stage contents
    decodePkg::ctrlT expCtrl = idleCtrl;
    decodePkg::regSelT expRegSel = '0;
    decodePkg::wordT expImm = '0;
    decodePkg::wordT expPc = '0;
    logic expCollision = 1'b0;
    logic prevLoad = 1'b0;

    // ALU op by funct3 with funct7 at its base value
    decodePkg::aluOpE aluByF3 [8] = '{decodePkg::ALU_ADD, decodePkg::ALU_SLL, decodePkg::ALU_SLT,
        decodePkg::ALU_SLTU, decodePkg::ALU_XOR, decodePkg::ALU_SRL, decodePkg::ALU_OR,
        decodePkg::ALU_AND};
    decodePkg::opcodeT writerOps [6] = '{`OPC_R_TYPE, `OPC_I_TYPE, `OPC_JAL, `OPC_JALR,
        `OPC_LUI, `OPC_AUIPC};

    decodeTop dut_i (
        .clk               (clk),
        .arstN             (arstN),
        .hold              (hold),
        .instruction       (instruction),
        .pcIn              (pcIn),
        .regSel            (regSel),
        .imm               (imm),
        .ctrl              (ctrl),
        .regWriteCollision (regWriteCollision),
        .pc                (pc)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic void refDecode(input decodePkg::wordT ins, output decodePkg::ctrlT c,
                                      output decodePkg::regSelT r, output decodePkg::wordT im);
        logic [2:0] f3;
        logic [6:0] f7;
        logic ok;
        decodePkg::wordT immI;
        f3 = ins[14:12];
        f7 = ins[31:25];
        immI = {{20{ins[31]}}, ins[31:20]};
        c = idleCtrl;
        r = {ins[19:15], ins[24:20], ins[11:7]};
        im = '0;
        ok = 1'b1;
        case (ins[6:0])
            `OPC_R_TYPE, `OPC_I_TYPE: begin
                c.aluToReg = 1'b1;
                c.aluOp = aluByF3[f3];
                if (ins[6:0] == `OPC_I_TYPE) begin
                    c.selB = decodePkg::SELB_IMM;
                    im = immI;
                end
                // funct7 only qualifies R-type and shift immediates
                if (ins[6:0] == `OPC_R_TYPE || f3 == `F3_SLL || f3 == `F3_SR) begin
                    ok = (f7 == `F7_BASE) || (f7 == `F7_ALT && (f3 == `F3_SR ||
                         (f3 == `F3_ADD_SUB && ins[6:0] == `OPC_R_TYPE)));
                    if (f7 == `F7_ALT && f3 == `F3_ADD_SUB)
                        c.aluOp = decodePkg::ALU_SUB;
                    if (f7 == `F7_ALT && f3 == `F3_SR)
                        c.aluOp = decodePkg::ALU_SRA;
                    if (ins[6:0] == `OPC_I_TYPE)
                        im = {27'b0, ins[24:20]};
                end
            end
            `OPC_LOAD: begin
                c.selB = decodePkg::SELB_IMM;
                c.memSize = decodePkg::memSizeE'(f3[1:0]);
                im = immI;
                case (f3)
                    `F3_LB, `F3_LH, `F3_LW: c.memOp = decodePkg::MEM_READ_SEXT;
                    `F3_LBU, `F3_LHU: c.memOp = decodePkg::MEM_READ_ZEXT;
                    default: ok = 1'b0;
                endcase
            end
            `OPC_STORE: begin
                c.selB = decodePkg::SELB_IMM;
                c.memOp = decodePkg::MEM_WRITE;
                c.memSize = decodePkg::memSizeE'(f3[1:0]);
                ok = !f3[2] && (f3[1:0] != 2'b11);
                im = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            `OPC_BRANCH: begin
                c.branch = 1'b1;
                im = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                case (f3)
                    `F3_BEQ: c.aluOp = decodePkg::ALU_BEQ;
                    `F3_BNE: c.aluOp = decodePkg::ALU_BNE;
                    `F3_BLT: c.aluOp = decodePkg::ALU_BLT;
                    `F3_BGE: c.aluOp = decodePkg::ALU_BGE;
                    `F3_BLTU: c.aluOp = decodePkg::ALU_BLTU;
                    `F3_BGEU: c.aluOp = decodePkg::ALU_BGEU;
                    default: ok = 1'b0;
                endcase
            end
            `OPC_JAL, `OPC_JALR: begin
                c.selA = 1'b1;
                c.selB = decodePkg::SELB_FOUR;
                c.aluToReg = 1'b1;
                c.jal = (ins[6:0] == `OPC_JAL);
                c.jalr = (ins[6:0] == `OPC_JALR);
                im = c.jal ? {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0} : immI;
            end
            `OPC_LUI, `OPC_AUIPC: begin
                c.selA = (ins[6:0] == `OPC_AUIPC);
                c.selB = decodePkg::SELB_IMM;
                c.aluToReg = 1'b1;
                im = {ins[31:12], 12'b0};
                if (ins[6:0] == `OPC_LUI)
                    r.rs1 = '0;
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            c = idleCtrl;
            im = '0;
        end
    endfunction

    // Random fields with the opcode and funct codes forced
    function automatic decodePkg::wordT makeInstr(input decodePkg::opcodeT opc,
                                                  input logic [2:0] f3, input logic [6:0] f7,
                                                  input logic setF7);
        decodePkg::wordT ins;
        ins = $random(seed);
        ins[6:0] = opc;
        ins[14:12] = f3;
        if (setF7)
            ins[31:25] = f7;
        return ins;
    endfunction

    task automatic checkCtrl(input string name, input decodePkg::ctrlT expVal,
                             input decodePkg::ctrlT actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s expected %h actual %h", name, expVal, actVal);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic checkRegSel(input string name, input decodePkg::regSelT expVal,
                               input decodePkg::regSelT actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s expected %h actual %h", name, expVal, actVal);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic checkWord(input string name, input decodePkg::wordT expVal,
                             input decodePkg::wordT actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s expected %h actual %h", name, expVal, actVal);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s expected %h actual %h", name, expVal, actVal);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic drive(input decodePkg::wordT ins, input logic holdVal);
        @(posedge clk);
        #2;
        instruction = ins;
        hold = holdVal;
        pcIn = $random(seed);
    endtask

    // Lets the last accepted instruction reach the compare
    task automatic endTest(input string name);
        @(posedge clk);
        @(negedge clk);
        #1;
        $display("%s test finished with %0d errors", name, failCount - failMark);
        failMark = failCount;
    endtask

    // Reference model of the stage register
    always @(posedge clk) begin
        if (arstN && !hold) begin
            refDecode(instruction, expCtrl, expRegSel, expImm);
            expCollision = prevLoad && expCtrl.aluToReg;
            prevLoad = (expCtrl.memOp == decodePkg::MEM_READ_SEXT) ||
                       (expCtrl.memOp == decodePkg::MEM_READ_ZEXT);
            expPc = pcIn;
        end
    end

    always @(negedge clk) begin
        if (compareOn) begin
            checkCtrl("ctrl", expCtrl, ctrl);
            checkRegSel("regSel", expRegSel, regSel);
            checkWord("imm", expImm, imm);
            checkWord("pc", expPc, pc);
            checkBit("regWriteCollision", expCollision, regWriteCollision);
        end
    end

    initial begin
        #(timeLimit);
        $display("Simulation timed out before all tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        decodePkg::wordT ins;
        clk = 1'b0;
        arstN = 1'b0;
        hold = 1'b1;
        instruction = '0;
        pcIn = '0;
        @(posedge clk);
        compareOn = 1'b1;
        repeat (resetCycles - 1) @(posedge clk);
        #2;
        arstN = 1'b1;
        repeat (3) drive('0, 1'b1);
        endTest("reset");

        for (int n = 0; n < 4; n++) begin
            for (int f = 0; f < 8; f++) begin
                drive(makeInstr(`OPC_R_TYPE, 3'(f), `F7_BASE, 1'b1), 1'b0);
                drive(makeInstr(`OPC_I_TYPE, 3'(f), (f == 5 && n[0]) ? `F7_ALT : `F7_BASE,
                                f == 1 || f == 5), 1'b0);
            end
            drive(makeInstr(`OPC_R_TYPE, `F3_ADD_SUB, `F7_ALT, 1'b1), 1'b0);
            drive(makeInstr(`OPC_R_TYPE, `F3_SR, `F7_ALT, 1'b1), 1'b0);
        end
        endTest("alu");

        // funct3 codes without a load or store give bubbles
        for (int n = 0; n < 3; n++) begin
            for (int f = 0; f < 8; f++) begin
                drive(makeInstr(`OPC_LOAD, 3'(f), 7'b0, 1'b0), 1'b0);
                drive(makeInstr(`OPC_STORE, 3'(f), 7'b0, 1'b0), 1'b0);
            end
        end
        endTest("memory");

        for (int n = 0; n < 3; n++) begin
            for (int f = 0; f < 8; f++)
                drive(makeInstr(`OPC_BRANCH, 3'(f), 7'b0, 1'b0), 1'b0);
            drive(makeInstr(`OPC_JAL, 3'(n), 7'b0, 1'b0), 1'b0);
            drive(makeInstr(`OPC_JALR, 3'b000, 7'b0, 1'b0), 1'b0);
            drive(makeInstr(`OPC_LUI, 3'(n), 7'b0, 1'b0), 1'b0);
            drive(makeInstr(`OPC_AUIPC, 3'(n), 7'b0, 1'b0), 1'b0);
        end
        // Bit 0 clear is never a 32-bit opcode
        for (int n = 0; n < 8; n++) begin
            ins = $random(seed);
            ins[0] = 1'b0;
            drive(ins, 1'b0);
        end
        drive(makeInstr(7'b0001111, 3'b000, 7'b0, 1'b0), 1'b0);
        drive(makeInstr(7'b1110011, 3'b000, 7'b0, 1'b0), 1'b0);
        drive(makeInstr(`OPC_R_TYPE, `F3_ADD_SUB, 7'b0000001, 1'b1), 1'b0);
        drive(makeInstr(`OPC_R_TYPE, `F3_XOR, `F7_ALT, 1'b1), 1'b0);
        drive(makeInstr(`OPC_I_TYPE, `F3_SLL, `F7_ALT, 1'b1), 1'b0);
        drive(makeInstr(`OPC_I_TYPE, `F3_SR, 7'b0100001, 1'b1), 1'b0);
        endTest("control");

        drive(makeInstr(`OPC_LOAD, `F3_LW, 7'b0, 1'b0), 1'b0);
        repeat (5) drive($random(seed), 1'b1);
        drive(makeInstr(`OPC_R_TYPE, `F3_OR, `F7_BASE, 1'b1), 1'b0);
        @(posedge clk);
        @(negedge clk);
        checkBit("regWriteCollision", 1'b1, regWriteCollision);
        endTest("hold");

        for (int n = 0; n < 6; n++) begin
            drive(makeInstr(`OPC_LOAD, n[0] ? `F3_LBU : `F3_LH, 7'b0, 1'b0), 1'b0);
            drive(makeInstr(writerOps[n], 3'b000, `F7_BASE, 1'b1), 1'b0);
        end
        drive(makeInstr(`OPC_LOAD, `F3_LB, 7'b0, 1'b0), 1'b0);
        drive(makeInstr(`OPC_STORE, `F3_SW, 7'b0, 1'b0), 1'b0);
        drive(makeInstr(`OPC_LOAD, `F3_LHU, 7'b0, 1'b0), 1'b0);
        drive(makeInstr(`OPC_BRANCH, `F3_BNE, 7'b0, 1'b0), 1'b0);
        drive(makeInstr(`OPC_LOAD, `F3_LW, 7'b0, 1'b0), 1'b0);
        drive(makeInstr(`OPC_LOAD, `F3_LBU, 7'b0, 1'b0), 1'b0);
        drive(makeInstr(`OPC_R_TYPE, `F3_AND, `F7_BASE, 1'b1), 1'b0);
        drive(makeInstr(`OPC_I_TYPE, `F3_ADD_SUB, 7'b0, 1'b0), 1'b0);
        endTest("load-use");

        $display("Checks passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/decodePkg.sv
hdl/controlDecoder.sv
hdl/immGen.sv
hdl/loadUseTracker.sv
hdl/decodeRegister.sv
hdl/decodeTop.sv
bench/decodeTopTb.sv

// ==== hdl/controlDecoder.sv ====
`include "decodeConsts.svh"

module controlDecoder (
    input  decodePkg::wordT   instruction,
    output decodePkg::ctrlT   nextCtrl,
    output decodePkg::regSelT nextRegSel,
    output decodePkg::immFmtE immFmt
);

    decodePkg::opcodeT opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic altBit;
    logic legal;
    decodePkg::ctrlT dec;
    decodePkg::immFmtE fmt;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign altBit = instruction[30];

    // Shared by register and immediate ALU forms
    function automatic decodePkg::aluOpE aluFromFunct3(input logic [2:0] f3, input logic alt);
        decodePkg::aluOpE op;
        case (f3)
            `F3_ADD_SUB: op = alt ? decodePkg::ALU_SUB : decodePkg::ALU_ADD;
            `F3_SLL:     op = decodePkg::ALU_SLL;
            `F3_SLT:     op = decodePkg::ALU_SLT;
            `F3_SLTU:    op = decodePkg::ALU_SLTU;
            `F3_XOR:     op = decodePkg::ALU_XOR;
            `F3_SR:      op = alt ? decodePkg::ALU_SRA : decodePkg::ALU_SRL;
            `F3_OR:      op = decodePkg::ALU_OR;
            default:     op = decodePkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        dec = decodePkg::CTRL_IDLE;
        fmt = decodePkg::IMM_NONE;
        legal = 1'b1;
        case (opcode)
            `OPC_R_TYPE: begin
                legal = (funct7 == `F7_BASE) ||
                        ((funct7 == `F7_ALT) && (funct3 == `F3_ADD_SUB || funct3 == `F3_SR));
                dec.aluOp = aluFromFunct3(funct3, altBit);
                dec.aluToReg = 1'b1;
            end
            `OPC_I_TYPE: begin
                // Shift immediates carry funct7 in the upper bits
                if (funct3 == `F3_SLL) begin
                    legal = (funct7 == `F7_BASE);
                end else if (funct3 == `F3_SR) begin
                    legal = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
                end
                dec.aluOp = aluFromFunct3(funct3, (funct3 == `F3_SR) && altBit);
                dec.selB = decodePkg::SELB_IMM;
                dec.aluToReg = 1'b1;
                fmt = (funct3 == `F3_SLL || funct3 == `F3_SR) ? decodePkg::IMM_SHAMT
                                                                : decodePkg::IMM_I;
            end
            `OPC_LOAD: begin
                dec.selB = decodePkg::SELB_IMM;
                dec.memOp = decodePkg::MEM_READ_SEXT;
                fmt = decodePkg::IMM_I;
                case (funct3)
                    `F3_LB:  dec.memSize = decodePkg::SIZE_BYTE;
                    `F3_LH:  dec.memSize = decodePkg::SIZE_HALF;
                    `F3_LW:  dec.memSize = decodePkg::SIZE_WORD;
                    `F3_LBU: begin
                        dec.memOp = decodePkg::MEM_READ_ZEXT;
                        dec.memSize = decodePkg::SIZE_BYTE;
                    end
                    `F3_LHU: begin
                        dec.memOp = decodePkg::MEM_READ_ZEXT;
                        dec.memSize = decodePkg::SIZE_HALF;
                    end
                    default: legal = 1'b0;
                endcase
            end
            `OPC_STORE: begin
                dec.selB = decodePkg::SELB_IMM;
                dec.memOp = decodePkg::MEM_WRITE;
                fmt = decodePkg::IMM_S;
                case (funct3)
                    `F3_SB:  dec.memSize = decodePkg::SIZE_BYTE;
                    `F3_SH:  dec.memSize = decodePkg::SIZE_HALF;
                    `F3_SW:  dec.memSize = decodePkg::SIZE_WORD;
                    default: legal = 1'b0;
                endcase
            end
            `OPC_BRANCH: begin
                dec.branch = 1'b1;
                fmt = decodePkg::IMM_B;
                case (funct3)
                    `F3_BEQ:  dec.aluOp = decodePkg::ALU_BEQ;
                    `F3_BNE:  dec.aluOp = decodePkg::ALU_BNE;
                    `F3_BLT:  dec.aluOp = decodePkg::ALU_BLT;
                    `F3_BGE:  dec.aluOp = decodePkg::ALU_BGE;
                    `F3_BLTU: dec.aluOp = decodePkg::ALU_BLTU;
                    `F3_BGEU: dec.aluOp = decodePkg::ALU_BGEU;
                    default:  legal = 1'b0;
                endcase
            end
            // Link address is PC + 4
            `OPC_JAL, `OPC_JALR: begin
                dec.selA = 1'b1;
                dec.selB = decodePkg::SELB_FOUR;
                dec.aluToReg = 1'b1;
                dec.jal = (opcode == `OPC_JAL);
                dec.jalr = (opcode == `OPC_JALR);
                fmt = (opcode == `OPC_JAL) ? decodePkg::IMM_J : decodePkg::IMM_I;
            end
            `OPC_LUI, `OPC_AUIPC: begin
                dec.selA = (opcode == `OPC_AUIPC);
                dec.selB = decodePkg::SELB_IMM;
                dec.aluToReg = 1'b1;
                fmt = decodePkg::IMM_U;
            end
            default: legal = 1'b0;
        endcase
    end

    assign nextCtrl = legal ? dec : decodePkg::CTRL_IDLE;
    assign immFmt = legal ? fmt : decodePkg::IMM_NONE;

    // LUI adds its immediate to x0
    assign nextRegSel.rs1 = (opcode == `OPC_LUI) ? '0 : instruction[19:15];
    assign nextRegSel.rs2 = instruction[24:20];
    assign nextRegSel.rd = instruction[11:7];

endmodule

// ==== hdl/decodeConsts.svh ====
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Word and register index widths
`define DEC_XLEN         32
`define DEC_REG_IDX_W    5

// Major opcodes
`define OPC_R_TYPE       7'b0110011
`define OPC_I_TYPE       7'b0010011
`define OPC_LOAD         7'b0000011
`define OPC_STORE        7'b0100011
`define OPC_BRANCH       7'b1100011
`define OPC_JAL          7'b1101111
`define OPC_JALR         7'b1100111
`define OPC_LUI          7'b0110111
`define OPC_AUIPC        7'b0010111

// ALU funct3
`define F3_ADD_SUB       3'b000
`define F3_SLL           3'b001
`define F3_SLT           3'b010
`define F3_SLTU          3'b011
`define F3_XOR           3'b100
`define F3_SR            3'b101
`define F3_OR            3'b110
`define F3_AND           3'b111

// Load and store funct3
`define F3_LB            3'b000
`define F3_LH            3'b001
`define F3_LW            3'b010
`define F3_LBU           3'b100
`define F3_LHU           3'b101
`define F3_SB            3'b000
`define F3_SH            3'b001
`define F3_SW            3'b010

// Branch funct3
`define F3_BEQ           3'b000
`define F3_BNE           3'b001
`define F3_BLT           3'b100
`define F3_BGE           3'b101
`define F3_BLTU          3'b110
`define F3_BGEU          3'b111

`define F7_BASE          7'b0000000
`define F7_ALT           7'b0100000

`endif

// ==== hdl/decodePkg.sv ====
`include "decodeConsts.svh"

package decodePkg;

    typedef logic [`DEC_XLEN-1:0] wordT;
    typedef logic [`DEC_REG_IDX_W-1:0] regIdxT;
    typedef logic [6:0] opcodeT;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLL  = 4'h5,
        ALU_SRL  = 4'h6,
        ALU_SRA  = 4'h7,
        ALU_SLT  = 4'h8,
        ALU_SLTU = 4'h9,
        ALU_BEQ  = 4'hA,
        ALU_BNE  = 4'hB,
        ALU_BLT  = 4'hC,
        ALU_BGE  = 4'hD,
        ALU_BLTU = 4'hE,
        ALU_BGEU = 4'hF
    } aluOpE;

    typedef enum logic [1:0] {
        SELB_RS2  = 2'b00,
        SELB_IMM  = 2'b01,
        SELB_FOUR = 2'b10
    } selBE;

    typedef enum logic [1:0] {
        MEM_DISABLE   = 2'b00,
        MEM_READ_SEXT = 2'b01,
        MEM_READ_ZEXT = 2'b10,
        MEM_WRITE     = 2'b11
    } memOpE;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } memSizeE;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_SHAMT,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } immFmtE;

    typedef struct packed {
        aluOpE   aluOp;
        logic    selA;      // 1 selects the PC
        selBE    selB;
        logic    aluToReg;
        memOpE   memOp;
        memSizeE memSize;
        logic    branch;
        logic    jal;
        logic    jalr;
    } ctrlT;

    typedef struct packed {
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;
    } regSelT;

    // Bubble and stage reset value
    localparam ctrlT CTRL_IDLE = '{
        aluOp:    ALU_ADD,
        selA:     1'b0,
        selB:     SELB_RS2,
        aluToReg: 1'b0,
        memOp:    MEM_DISABLE,
        memSize:  SIZE_BYTE,
        branch:   1'b0,
        jal:      1'b0,
        jalr:     1'b0
    };

endpackage

// ==== hdl/decodeRegister.sv ====
module decodeRegister (
    input  logic              clk,
    input  logic              arstN,
    input  logic              hold,
    input  decodePkg::ctrlT   nextCtrl,
    input  decodePkg::regSelT nextRegSel,
    input  decodePkg::wordT   nextImm,
    input  decodePkg::wordT   pcIn,
    output decodePkg::ctrlT   ctrl,
    output decodePkg::regSelT regSel,
    output decodePkg::wordT   imm,
    output decodePkg::wordT   pc
);

    // Control bundle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrl <= decodePkg::CTRL_IDLE;
        end else if (!hold) begin
            ctrl <= nextCtrl;
        end
    end

    // Operand fields and PC
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regSel <= '0;
            imm <= '0;
            pc <= '0;
        end else if (!hold) begin
            regSel <= nextRegSel;
            imm <= nextImm;
            pc <= pcIn;
        end
    end

endmodule

// ==== hdl/decodeTop.sv ====
module decodeTop (
    input  logic              clk,
    input  logic              arstN,
    input  logic              hold,
    input  decodePkg::wordT   instruction,
    input  decodePkg::wordT   pcIn,
    output decodePkg::regSelT regSel,
    output decodePkg::wordT   imm,
    output decodePkg::ctrlT   ctrl,
    output logic              regWriteCollision,
    output decodePkg::wordT   pc
);

    decodePkg::ctrlT nextCtrl;
    decodePkg::regSelT nextRegSel;
    decodePkg::immFmtE immFmt;
    decodePkg::wordT nextImm;

    controlDecoder ctrlDec (
        .instruction (instruction),
        .nextCtrl    (nextCtrl),
        .nextRegSel  (nextRegSel),
        .immFmt      (immFmt)
    );

    immGen immBuilder (
        .instruction (instruction),
        .immFmt      (immFmt),
        .imm         (nextImm)
    );

    loadUseTracker tracker (
        .clk               (clk),
        .arstN             (arstN),
        .hold              (hold),
        .nextCtrl          (nextCtrl),
        .regWriteCollision (regWriteCollision)
    );

    decodeRegister stageReg (
        .clk        (clk),
        .arstN      (arstN),
        .hold       (hold),
        .nextCtrl   (nextCtrl),
        .nextRegSel (nextRegSel),
        .nextImm    (nextImm),
        .pcIn       (pcIn),
        .ctrl       (ctrl),
        .regSel     (regSel),
        .imm        (imm),
        .pc         (pc)
    );

endmodule

// ==== hdl/immGen.sv ====
module immGen (
    input  decodePkg::wordT   instruction,
    input  decodePkg::immFmtE immFmt,
    output decodePkg::wordT   imm
);

    logic signBit;

    assign signBit = instruction[31];

    always_comb begin
        case (immFmt)
            decodePkg::IMM_I: begin
                imm = {{20{signBit}}, instruction[31:20]};
            end
            decodePkg::IMM_SHAMT: begin
                imm = {27'b0, instruction[24:20]};
            end
            decodePkg::IMM_S: begin
                imm = {{20{signBit}}, instruction[31:25], instruction[11:7]};
            end
            // Offsets in halfwords
            decodePkg::IMM_B: begin
                imm = {{19{signBit}}, signBit, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            end
            decodePkg::IMM_U: begin
                imm = {instruction[31:12], 12'b0};
            end
            decodePkg::IMM_J: begin
                imm = {{11{signBit}}, signBit, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== hdl/loadUseTracker.sv ====
module loadUseTracker (
    input  logic            clk,
    input  logic            arstN,
    input  logic            hold,
    input  decodePkg::ctrlT nextCtrl,
    output logic            regWriteCollision
);

    logic prevIsLoad;
    logic curIsLoad;

    assign curIsLoad = (nextCtrl.memOp == decodePkg::MEM_READ_SEXT) ||
                       (nextCtrl.memOp == decodePkg::MEM_READ_ZEXT);

    // Load result not ready for an ALU writer right behind it
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            prevIsLoad <= 1'b0;
            regWriteCollision <= 1'b0;
        end else if (!hold) begin
            prevIsLoad <= curIsLoad;
            regWriteCollision <= prevIsLoad && nextCtrl.aluToReg;
        end
    end

endmodule
